//--- vlog.f
+incdir+src
src/fetch_pkg.sv
src/fetch_addr_gen.sv
src/fetch_pc_track.sv
src/fetch_instr_out.sv
src/fetch_top.sv
sim/fetch_tb.sv

//--- Bender.yml
package:
  name: fetch_stage

export_include_dirs:
  - src

sources:
  - include_dirs:
      - src
    files:
      - src/fetch_pkg.sv
      - src/fetch_addr_gen.sv
      - src/fetch_pc_track.sv
      - src/fetch_instr_out.sv
      - src/fetch_top.sv
  - target: test
    include_dirs:
      - src
    files:
      - sim/fetch_tb.sv

//--- sim/fetch_tb.sv
// Testbench for the instruction fetch stage
// Table-driven stimulus with a synchronous memory model and a reference
// model of the fetch address and output PC

`timescale 1ns/1ps

`include "fetch_params.svh"

module fetch_tb;

    localparam int CLK_PERIOD  = 10;
    localparam int N_DIRECTED  = 18;
    localparam int N_GROUPS    = 5;
    localparam int N_ROWS      = N_DIRECTED + 4 * N_GROUPS;
    localparam int MAX_REP     = 8;
    localparam int WATCHDOG_NS = (N_ROWS * MAX_REP + 40) * CLK_PERIOD;

    typedef struct packed {
        logic             en;
        logic             jump;
        logic             ctx;
        logic             take;
        logic             rb;
        fetch_pkg::addr_t jt;
        fetch_pkg::addr_t ct;
        fetch_pkg::addr_t bt;
        logic [7:0]       rep;
    } row_t;

    logic              clk;
    logic              reset_n;
    logic              sys_reset_i;
    logic              enable_i;
    logic              jump_i;
    logic              ctx_switch_i;
    logic              bp_take_i;
    logic              jump_rollback_i;
    fetch_pkg::addr_t  jump_target_i;
    fetch_pkg::addr_t  ctx_switch_target_i;
    fetch_pkg::addr_t  bp_target_i;
    fetch_pkg::instr_t instruction_data_i;
    logic              jumping_o;
    logic              bp_rollback_o;
    fetch_pkg::addr_t  instruction_address_o;
    fetch_pkg::instr_t instruction_o;
    fetch_pkg::addr_t  pc_o;

    row_t   rows [N_ROWS];
    int     n_rows;
    integer seed;
    int     addr_errors;
    int     instr_errors;
    int     flag_errors;
    int     other_errors;
    int     rb_count;

    // Reference model state
    fetch_pkg::addr_t exp_addr;
    fetch_pkg::addr_t exp_rb;
    fetch_pkg::addr_t pc_expect;
    fetch_pkg::addr_t pending_pc;
    fetch_pkg::addr_t mem_addr_q;
    logic             pc_known;
    logic             wait_clear;
    logic             expect_jump;
    logic             check_reset_next;
    logic             rb_window;

    fetch_top i_dut (
        .clk                   (clk),
        .reset_n               (reset_n),
        .sys_reset_i           (sys_reset_i),
        .enable_i              (enable_i),
        .jump_i                (jump_i),
        .ctx_switch_i          (ctx_switch_i),
        .jump_target_i         (jump_target_i),
        .ctx_switch_target_i   (ctx_switch_target_i),
        .bp_take_i             (bp_take_i),
        .jump_rollback_i       (jump_rollback_i),
        .bp_target_i           (bp_target_i),
        .instruction_data_i    (instruction_data_i),
        .jumping_o             (jumping_o),
        .bp_rollback_o         (bp_rollback_o),
        .instruction_address_o (instruction_address_o),
        .instruction_o         (instruction_o),
        .pc_o                  (pc_o)
    );

    always #(CLK_PERIOD / 2) clk = ~clk;

    function automatic fetch_pkg::instr_t mem_word(input fetch_pkg::addr_t addr);
        mem_word = (addr ^ 32'hA5A5_0000) | 32'h0000_0003;
    endfunction

    function automatic fetch_pkg::addr_t word_align(input fetch_pkg::addr_t addr);
        word_align = {addr[31:2], 2'b00};
    endfunction

    // Word for last cycle's address, ready for the next rising edge
    always @(negedge clk) begin
        instruction_data_i <= mem_word(mem_addr_q);
        mem_addr_q         <= instruction_address_o;
    end

    ////////////////////////////////////////////////////////////
    // Compare tasks
    ////////////////////////////////////////////////////////////

    task automatic check_addr(input string name, input fetch_pkg::addr_t got,
                              input fetch_pkg::addr_t exp);
        if (got !== exp) begin
            $display("error: %s is %h, expected %h at %0t", name, got, exp, $time);
            addr_errors++;
        end
    endtask

    task automatic check_instr(input string name, input fetch_pkg::instr_t got,
                               input fetch_pkg::instr_t exp);
        if (got !== exp) begin
            $display("error: %s is %h, expected %h at %0t", name, got, exp, $time);
            instr_errors++;
        end
    endtask

    task automatic check_flag(input string name, input logic got, input logic exp);
        if (got !== exp) begin
            $display("error: %s is %h, expected %h at %0t", name, got, exp, $time);
            flag_errors++;
        end
    endtask

    task automatic check_reset_state();
        check_addr("instruction_address_o", instruction_address_o, `FETCH_START_ADDR);
        check_instr("instruction_o", instruction_o, `FETCH_NOP);
        check_addr("pc_o", pc_o, '0);
        check_flag("jumping_o", jumping_o, 1'b1);
        check_flag("bp_rollback_o", bp_rollback_o, 1'b0);
    endtask

    // bp_rollback_o must show up exactly once after each rollback
    task automatic close_rb_window();
        if (rb_window) begin
            rb_window = 1'b0;
            if (rb_count != 1) begin
                $display("Rollback flag was seen high %0d times after a rollback, not once",
                         rb_count);
                other_errors++;
            end
        end
    endtask

    task automatic sample_outputs();
        check_addr("instruction_address_o", instruction_address_o, exp_addr);
        if (check_reset_next) begin
            check_reset_state();
            check_reset_next = 1'b0;
        end
        if (expect_jump) begin
            check_flag("jumping_o", jumping_o, 1'b1);
            expect_jump = 1'b0;
        end
        // Output is valid from the redirect target once jumping_o drops
        if (wait_clear && !jumping_o) begin
            wait_clear = 1'b0;
            pc_known   = 1'b1;
            pc_expect  = pending_pc;
        end
        if (pc_known) begin
            check_addr("pc_o", pc_o, pc_expect);
            if (!jumping_o && !bp_rollback_o) begin
                check_instr("instruction_o", instruction_o, mem_word(pc_expect));
            end
        end
        if (rb_window && bp_rollback_o) begin
            rb_count++;
        end
    endtask

    ////////////////////////////////////////////////////////////
    // Reference model and stimulus
    ////////////////////////////////////////////////////////////

    task automatic update_models(input row_t r);
        logic             redirect;
        fetch_pkg::addr_t next;
        redirect = r.ctx || r.jump || (r.en && r.take);
        if (redirect || r.rb) begin
            close_rb_window();
        end
        if (r.ctx) begin
            next = word_align(r.ct);
        end else if (r.jump) begin
            next = word_align(r.jt);
        end else if (r.rb) begin
            next = exp_rb;
        end else if (r.en && r.take) begin
            next = word_align(r.bt);
        end else if (r.en) begin
            next = exp_addr + `FETCH_ADDR_STEP;
        end else begin
            next = exp_addr;
        end
        if (r.en && r.take) begin
            exp_rb = exp_addr;
        end
        exp_addr = next;
        if (r.en && pc_known) begin
            pc_expect = pc_expect + `FETCH_ADDR_STEP;
        end
        if (redirect) begin
            pc_known    = 1'b0;
            wait_clear  = 1'b1;
            expect_jump = 1'b1;
            pending_pc  = next;
        end
        // PC after a rollback is not tied to the fetch stream until the next redirect
        if (r.rb) begin
            pc_known   = 1'b0;
            wait_clear = 1'b0;
            rb_window  = 1'b1;
            rb_count   = 0;
        end
    endtask

    task automatic apply_cycle(input row_t r);
        @(negedge clk);
        sample_outputs();
        sys_reset_i         = 1'b0;
        enable_i            = r.en;
        jump_i              = r.jump;
        ctx_switch_i        = r.ctx;
        bp_take_i           = r.take;
        jump_rollback_i     = r.rb;
        jump_target_i       = r.jt;
        ctx_switch_target_i = r.ct;
        bp_target_i         = r.bt;
        update_models(r);
    endtask

    task automatic apply_rows(input int first, input int last);
        int i;
        for (i = first; i <= last; i++) begin
            repeat (rows[i].rep) apply_cycle(rows[i]);
        end
    endtask

    task automatic pulse_sys_reset();
        @(negedge clk);
        sample_outputs();
        sys_reset_i     = 1'b1;
        enable_i        = 1'b0;
        jump_i          = 1'b0;
        ctx_switch_i    = 1'b0;
        bp_take_i       = 1'b0;
        jump_rollback_i = 1'b0;
        close_rb_window();
        exp_addr         = `FETCH_START_ADDR;
        pc_known         = 1'b0;
        wait_clear       = 1'b1;
        pending_pc       = `FETCH_START_ADDR;
        check_reset_next = 1'b1;
    endtask

    task automatic add_row(input logic en, input logic jump, input logic ctx,
                           input logic take, input logic rb, input fetch_pkg::addr_t jt,
                           input fetch_pkg::addr_t ct, input fetch_pkg::addr_t bt,
                           input logic [7:0] rep);
        rows[n_rows] = '{en, jump, ctx, take, rb, jt, ct, bt, rep};
        n_rows++;
    endtask

    task automatic build_table();
        int               g;
        int               kind;
        logic [7:0]       gap;
        logic [31:0]      rnd;
        fetch_pkg::addr_t tj;
        fetch_pkg::addr_t tc;
        fetch_pkg::addr_t tb;
        // Columns en jump ctx take rb jt ct bt rep
        add_row(1, 0, 0, 0, 0, '0, '0, '0, 8);
        add_row(0, 0, 0, 0, 0, '0, '0, '0, 3);
        add_row(1, 0, 0, 0, 0, '0, '0, '0, 6);
        add_row(1, 1, 0, 0, 0, 32'h0000_1002, '0, '0, 1);
        add_row(1, 0, 0, 0, 0, '0, '0, '0, 5);
        add_row(1, 0, 1, 0, 0, '0, 32'h0000_2001, '0, 1);
        add_row(1, 0, 0, 0, 0, '0, '0, '0, 5);
        // Jump and context switch together
        add_row(1, 1, 1, 0, 0, 32'h0000_3000, 32'h0000_4003, '0, 1);
        add_row(1, 0, 0, 0, 0, '0, '0, '0, 4);
        // Take while stalled is ignored
        add_row(0, 0, 0, 1, 0, '0, '0, 32'h0000_7000, 2);
        add_row(1, 0, 0, 0, 0, '0, '0, '0, 5);
        add_row(1, 0, 0, 1, 0, '0, '0, 32'h0000_5006, 1);
        // Stall right after a take
        add_row(0, 0, 0, 0, 0, '0, '0, '0, 2);
        add_row(1, 0, 0, 0, 0, '0, '0, '0, 4);
        add_row(1, 0, 0, 0, 1, '0, '0, '0, 1);
        add_row(1, 0, 0, 0, 0, '0, '0, '0, 6);
        // Jump while stalled
        add_row(0, 1, 0, 0, 0, 32'h0000_6000, '0, '0, 1);
        add_row(1, 0, 0, 0, 0, '0, '0, '0, 6);
        // Random gaps and redirects with an enabled run after each redirect
        for (g = 0; g < N_GROUPS; g++) begin
            gap  = 8'(1 + {$random(seed)} % 3);
            kind = {$random(seed)} % 4;
            rnd  = $random(seed);
            tj   = $random(seed);
            tc   = $random(seed);
            tb   = $random(seed);
            add_row(0, 0, 0, 0, 0, '0, '0, '0, gap);
            add_row(1, 0, 0, 0, 0, '0, '0, '0, 4);
            add_row(rnd[0] || kind == 3, kind == 0 || kind == 2, kind == 1 || kind == 2,
                    kind == 3, 0, tj, tc, tb, 1);
            add_row(1, 0, 0, 0, 0, '0, '0, '0, 4);
        end
    endtask

    initial begin
        #(WATCHDOG_NS);
        $display("Watchdog expired after %0d ns before the stimulus table finished",
                 WATCHDOG_NS);
        $display("Test FAILED");
        $finish;
    end

    initial begin
        clk                 = 1'b0;
        reset_n             = 1'b0;
        sys_reset_i         = 1'b0;
        enable_i            = 1'b0;
        jump_i              = 1'b0;
        ctx_switch_i        = 1'b0;
        bp_take_i           = 1'b0;
        jump_rollback_i     = 1'b0;
        jump_target_i       = '0;
        ctx_switch_target_i = '0;
        bp_target_i         = '0;
        instruction_data_i  = '0;
        mem_addr_q          = `FETCH_START_ADDR;
        seed                = 32'h98f9_0816;
        n_rows              = 0;
        addr_errors         = 0;
        instr_errors        = 0;
        flag_errors         = 0;
        other_errors        = 0;
        rb_count            = 0;
        exp_addr            = `FETCH_START_ADDR;
        exp_rb              = `FETCH_START_ADDR;
        pc_expect           = `FETCH_START_ADDR;
        pending_pc          = `FETCH_START_ADDR;
        pc_known            = 1'b0;
        wait_clear          = 1'b1;
        expect_jump         = 1'b0;
        check_reset_next    = 1'b0;
        rb_window           = 1'b0;
        build_table();

        repeat (4) @(posedge clk);
        @(negedge clk);
        reset_n = 1'b1;
        check_reset_state();

        apply_rows(0, N_DIRECTED - 1);
        pulse_sys_reset();
        apply_rows(N_DIRECTED, n_rows - 1);
        @(negedge clk);
        sample_outputs();
        close_rb_window();

        $display("Errors: address %0d, instruction %0d, flag %0d, other %0d",
                 addr_errors, instr_errors, flag_errors, other_errors);
        if (addr_errors + instr_errors + flag_errors + other_errors == 0) begin
            $display("Test OK");
        end else begin
            $display("Test FAILED");
        end
        $finish;
    end

endmodule

//--- src/fetch_top.sv
// Instruction fetch stage, 32-bit RISC-V
// Address generation, PC tracking and instruction output

`timescale 1ns/1ps

module fetch_top (
    input  logic             clk,
    input  logic             reset_n,
    input  logic             sys_reset_i,
    input  logic             enable_i,
    input  logic             jump_i,
    input  logic             ctx_switch_i,
    input  fetch_pkg::addr_t  jump_target_i,
    input  fetch_pkg::addr_t  ctx_switch_target_i,
    input  logic             bp_take_i,
    input  logic             jump_rollback_i,
    input  fetch_pkg::addr_t  bp_target_i,
    input  fetch_pkg::instr_t instruction_data_i,
    output logic             jumping_o,
    output logic             bp_rollback_o,
    output fetch_pkg::addr_t  instruction_address_o,
    output fetch_pkg::instr_t instruction_o,
    output fetch_pkg::addr_t  pc_o
);

    // Combinational redirect strobe from the address side
    logic redirect;

    fetch_addr_gen i_addr_gen (
        .clk                   (clk),
        .reset_n               (reset_n),
        .sys_reset_i           (sys_reset_i),
        .enable_i              (enable_i),
        .jump_i                (jump_i),
        .ctx_switch_i          (ctx_switch_i),
        .bp_take_i             (bp_take_i),
        .jump_rollback_i       (jump_rollback_i),
        .jump_target_i         (jump_target_i),
        .ctx_switch_target_i   (ctx_switch_target_i),
        .bp_target_i           (bp_target_i),
        .redirect_o            (redirect),
        .instruction_address_o (instruction_address_o)
    );

    fetch_pc_track i_pc_track (
        .clk                 (clk),
        .reset_n             (reset_n),
        .sys_reset_i         (sys_reset_i),
        .enable_i            (enable_i),
        .jump_i              (jump_i),
        .ctx_switch_i        (ctx_switch_i),
        .bp_take_i           (bp_take_i),
        .jump_rollback_i     (jump_rollback_i),
        .redirect_i          (redirect),
        .jump_target_i       (jump_target_i),
        .ctx_switch_target_i (ctx_switch_target_i),
        .bp_target_i         (bp_target_i),
        .jumping_o           (jumping_o),
        .bp_rollback_o       (bp_rollback_o),
        .pc_o                (pc_o)
    );

    fetch_instr_out i_instr_out (
        .clk                (clk),
        .reset_n            (reset_n),
        .sys_reset_i        (sys_reset_i),
        .enable_i           (enable_i),
        .instruction_data_i (instruction_data_i),
        .instruction_o      (instruction_o)
    );

endmodule

//--- src/fetch_instr_out.sv
// Fetch instruction output
// Keeps the memory word across a stall and registers it on enable

`timescale 1ns/1ps

`include "fetch_params.svh"

module fetch_instr_out (
    input  logic             clk,
    input  logic             reset_n,
    input  logic             sys_reset_i,
    input  logic             enable_i,
    input  fetch_pkg::instr_t instruction_data_i,
    output fetch_pkg::instr_t instruction_o
);

    logic             enable_r;
    fetch_pkg::instr_t idata_held;
    fetch_pkg::instr_t idata_fetched;

    always_ff @(posedge clk or negedge reset_n) begin
        if (!reset_n) begin
            enable_r <= 1'b0;
        end else begin
            enable_r <= enable_i;
        end
    end

    // Word arriving in the first stalled cycle would be lost otherwise
    always_ff @(posedge clk or negedge reset_n) begin
        if (!reset_n) begin
            idata_held <= `FETCH_NOP;
        end else if (!enable_i && enable_r) begin
            idata_held <= instruction_data_i;
        end
    end

    assign idata_fetched = enable_r ? instruction_data_i : idata_held;

    ////////////////////////////////////////////////////////////
    // Output register
    ////////////////////////////////////////////////////////////

    always_ff @(posedge clk or negedge reset_n) begin
        if (!reset_n) begin
            instruction_o <= `FETCH_NOP;
        end else if (sys_reset_i) begin
            instruction_o <= `FETCH_NOP;
        end else if (enable_i) begin
            instruction_o <= idata_fetched;
        end
    end

endmodule

//--- src/fetch_pc_track.sv
// Fetch PC tracking
// Keeps the redirect flags and targets, the rollback state and the PC
// of the instruction currently on the output

`timescale 1ns/1ps

`include "fetch_params.svh"

module fetch_pc_track (
    input  logic            clk,
    input  logic            reset_n,
    input  logic            sys_reset_i,
    input  logic            enable_i,
    input  logic            jump_i,
    input  logic            ctx_switch_i,
    input  logic            bp_take_i,
    input  logic            jump_rollback_i,
    input  logic            redirect_i,
    input  fetch_pkg::addr_t jump_target_i,
    input  fetch_pkg::addr_t ctx_switch_target_i,
    input  fetch_pkg::addr_t bp_target_i,
    output logic            jumping_o,
    output logic            bp_rollback_o,
    output fetch_pkg::addr_t pc_o
);

    localparam fetch_pkg::addr_t START_ADDR = `FETCH_START_ADDR;

    logic                jumped_r;
    logic                jumped_r2;
    logic                rollback_r;
    fetch_pkg::redirect_e reason;
    fetch_pkg::redirect_e reason_r;
    fetch_pkg::addr_t     ctx_target_r;
    fetch_pkg::addr_t     jump_target_r;
    fetch_pkg::addr_t     bp_target_r;
    fetch_pkg::addr_t     pc_jumped;
    fetch_pkg::addr_t     pc_jumped_r;
    fetch_pkg::addr_t     pc_rollback_r;
    fetch_pkg::addr_t     pc_base;
    fetch_pkg::addr_t     pc_update;

    ////////////////////////////////////////////////////////////
    // Redirect flags
    ////////////////////////////////////////////////////////////

    always_ff @(posedge clk or negedge reset_n) begin
        if (!reset_n) begin
            jumped_r  <= 1'b1;
            jumped_r2 <= 1'b1;
            jumping_o <= 1'b1;
        end else if (sys_reset_i) begin
            jumped_r  <= 1'b1;
            jumped_r2 <= 1'b1;
            jumping_o <= 1'b1;
        end else begin
            if (redirect_i) begin
                jumped_r <= 1'b1;
            end else if (enable_i || jump_rollback_i) begin
                jumped_r <= 1'b0;
            end
            // Second stage marks when pc_o must load the target
            if (enable_i) begin
                jumped_r2 <= jumped_r && !jump_rollback_i;
            end
            // Output stays stale for two cycles after a redirect
            if (redirect_i || (jumped_r && !jump_rollback_i)) begin
                jumping_o <= 1'b1;
            end else if (enable_i || jump_rollback_i) begin
                jumping_o <= 1'b0;
            end
        end
    end

    ////////////////////////////////////////////////////////////
    // Redirect reason and targets
    ////////////////////////////////////////////////////////////

    always_comb begin
        if (ctx_switch_i) begin
            reason = fetch_pkg::REDIR_CTX;
        end else if (jump_i) begin
            reason = fetch_pkg::REDIR_JUMP;
        end else if (enable_i && bp_take_i) begin
            reason = fetch_pkg::REDIR_PRED;
        end else begin
            reason = fetch_pkg::REDIR_NONE;
        end
    end

    // Targets keep the word alignment of the fetch address
    always_ff @(posedge clk or negedge reset_n) begin
        if (!reset_n) begin
            reason_r      <= fetch_pkg::REDIR_NONE;
            ctx_target_r  <= START_ADDR;
            jump_target_r <= START_ADDR;
            bp_target_r   <= START_ADDR;
        end else if (sys_reset_i) begin
            reason_r      <= fetch_pkg::REDIR_NONE;
            ctx_target_r  <= START_ADDR;
            jump_target_r <= START_ADDR;
            bp_target_r   <= START_ADDR;
        end else begin
            // Reason holds through a stall until the target is loaded
            if (redirect_i || enable_i) begin
                reason_r <= reason;
            end
            if (ctx_switch_i) begin
                ctx_target_r <= {ctx_switch_target_i[31:2], 2'b00};
            end
            if (jump_i) begin
                jump_target_r <= {jump_target_i[31:2], 2'b00};
            end
            if (enable_i && bp_take_i) begin
                bp_target_r <= {bp_target_i[31:2], 2'b00};
            end
        end
    end

    // Jump target also serves the reset state with no reason
    always_comb begin
        unique case (reason_r)
            fetch_pkg::REDIR_CTX:  pc_jumped = ctx_target_r;
            fetch_pkg::REDIR_PRED: pc_jumped = bp_target_r;
            default:               pc_jumped = jump_target_r;
        endcase
    end

    always_ff @(posedge clk or negedge reset_n) begin
        if (!reset_n) begin
            pc_jumped_r <= START_ADDR;
        end else if (jumped_r) begin
            pc_jumped_r <= pc_jumped;
        end
    end

    ////////////////////////////////////////////////////////////
    // Rollback
    ////////////////////////////////////////////////////////////

    always_ff @(posedge clk or negedge reset_n) begin
        if (!reset_n) begin
            rollback_r    <= 1'b0;
            bp_rollback_o <= 1'b0;
        end else if (sys_reset_i) begin
            rollback_r    <= 1'b0;
            bp_rollback_o <= 1'b0;
        end else begin
            if (jump_rollback_i) begin
                rollback_r <= 1'b1;
            end else if (enable_i) begin
                rollback_r <= 1'b0;
            end
            if (enable_i) begin
                bp_rollback_o <= rollback_r;
            end
        end
    end

    // PC to resume counting from after a rollback
    always_ff @(posedge clk or negedge reset_n) begin
        if (!reset_n) begin
            pc_rollback_r <= '0;
        end else if (rollback_r) begin
            pc_rollback_r <= pc_o;
        end
    end

    ////////////////////////////////////////////////////////////
    // Output PC
    ////////////////////////////////////////////////////////////

    assign pc_base   = bp_rollback_o ? pc_rollback_r : pc_o;
    assign pc_update = jumped_r2 ? pc_jumped_r
                                 : pc_base + fetch_pkg::addr_t'(`FETCH_ADDR_STEP);

    always_ff @(posedge clk or negedge reset_n) begin
        if (!reset_n) begin
            pc_o <= '0;
        end else if (sys_reset_i) begin
            pc_o <= '0;
        end else if (enable_i) begin
            pc_o <= pc_update;
        end
    end

endmodule

//--- src/fetch_addr_gen.sv
// Fetch address generator
// Picks the next word address in fixed priority and holds the
// instruction address register, plus the rollback return address

`timescale 1ns/1ps

`include "fetch_params.svh"

module fetch_addr_gen (
    input  logic            clk,
    input  logic            reset_n,
    input  logic            sys_reset_i,
    input  logic            enable_i,
    input  logic            jump_i,
    input  logic            ctx_switch_i,
    input  logic            bp_take_i,
    input  logic            jump_rollback_i,
    input  fetch_pkg::addr_t jump_target_i,
    input  fetch_pkg::addr_t ctx_switch_target_i,
    input  fetch_pkg::addr_t bp_target_i,
    output logic            redirect_o,
    output fetch_pkg::addr_t instruction_address_o
);

    localparam fetch_pkg::addr_t START_ADDR = `FETCH_START_ADDR;

    logic             take_accepted;
    fetch_pkg::waddr_t iaddr_cur;
    fetch_pkg::waddr_t iaddr_advance;
    fetch_pkg::waddr_t iaddr_rollback;
    fetch_pkg::waddr_t iaddr_next;

    // A take only counts while the stage may advance
    assign take_accepted = enable_i && bp_take_i;
    assign redirect_o    = ctx_switch_i || jump_i || take_accepted;

    assign iaddr_cur     = instruction_address_o[31:2];
    assign iaddr_advance = iaddr_cur + fetch_pkg::waddr_t'(`FETCH_ADDR_STEP / 4);

    ////////////////////////////////////////////////////////////
    // Next address select
    ////////////////////////////////////////////////////////////

    always_comb begin
        if (ctx_switch_i) begin
            iaddr_next = ctx_switch_target_i[31:2];
        end else if (jump_i) begin
            iaddr_next = jump_target_i[31:2];
        end else if (jump_rollback_i) begin
            iaddr_next = iaddr_rollback;
        end else if (take_accepted) begin
            iaddr_next = bp_target_i[31:2];
        end else begin
            iaddr_next = iaddr_advance;
        end
    end

    ////////////////////////////////////////////////////////////
    // Address registers
    ////////////////////////////////////////////////////////////

    // Holds on stall unless a redirect or rollback arrives
    always_ff @(posedge clk or negedge reset_n) begin
        if (!reset_n) begin
            instruction_address_o <= START_ADDR;
        end else if (sys_reset_i) begin
            instruction_address_o <= START_ADDR;
        end else if (redirect_o || jump_rollback_i || enable_i) begin
            instruction_address_o <= {iaddr_next, 2'b00};
        end
    end

    // Word in flight when the prediction was taken
    always_ff @(posedge clk or negedge reset_n) begin
        if (!reset_n) begin
            iaddr_rollback <= START_ADDR[31:2];
        end else if (take_accepted) begin
            iaddr_rollback <= iaddr_cur;
        end
    end

endmodule

//--- src/fetch_pkg.sv
// Fetch stage types
// Address, word address, instruction word and redirect reason

package fetch_pkg;

    // Byte address
    typedef logic [31:0] addr_t;

    // Word address, byte address bits 31:2
    typedef logic [29:0] waddr_t;

    // Instruction word as read from memory
    typedef logic [31:0] instr_t;

    // Why the fetch address was redirected, one-hot
    typedef enum logic [3:0] {
        REDIR_NONE = 4'b0001,
        REDIR_CTX  = 4'b0010,
        REDIR_JUMP = 4'b0100,
        REDIR_PRED = 4'b1000
    } redirect_e;

endpackage

//--- src/fetch_params.svh
// Fetch stage constants
// Reset address, reset instruction word and sequential fetch step

`ifndef FETCH_PARAMS_SVH
`define FETCH_PARAMS_SVH

// Address of the first fetch after reset or sys_reset
`define FETCH_START_ADDR 32'h0000_0000

// addi x0, x0, 0 shown on the output until real data arrives
`define FETCH_NOP 32'h0000_0013

// Byte step between two sequential fetches
`define FETCH_ADDR_STEP 4

`endif
